// ==== src/mul_settings.svh ====
/* Build settings for the RV32M multiply unit and its AXI4-Lite register port.
   MUL_ACC_W must leave the accuracy below MUL_XLEN, and register offsets must be word aligned. */
`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

// Operand and result width
`define MUL_XLEN 32

// Accuracy field, k clears k low bits of the second operand
`define MUL_ACC_W 4

// 0 makes every product exact whatever the accuracy register holds
`define MUL_APPROX_ENABLE 1

// Register port address width
`define AXIL_ADDR_W 8

// Register map, byte offsets
`define REG_RS1    8'h00
`define REG_RS2    8'h04
`define REG_INSN   8'h08
`define REG_ACC    8'h0C
`define REG_CTRL   8'h10
`define REG_STATUS 8'h14
`define REG_RESULT 8'h18

`endif

// ==== src/mul_pkg.sv ====
/* Types shared by the decoder, the multiply unit and the register block.
   Widths follow mul_settings.svh; the op encoding equals funct3[1:0] of the M extension. */
`include "mul_settings.svh"

package mul_pkg;

  // Multiply flavours, encoded as funct3[1:0]
  typedef enum logic [1:0] {
    op_mul    = 2'd0,
    op_mulh   = 2'd1,
    op_mulhsu = 2'd2,
    op_mulhu  = 2'd3
  } mul_op_e;

  // Decoder output, 6 bits
  typedef struct packed {
    mul_op_e op;
    // Operand signedness
    logic    rs1_signed;
    logic    rs2_signed;
    // Upper product word wanted
    logic    high;
    // One of the four multiplies
    logic    legal;
  } mul_decoded_t;

  // One multiply request as loaded by the host
  typedef struct packed {
    logic [`MUL_XLEN-1:0]  rs1;
    logic [`MUL_XLEN-1:0]  rs2;
    logic [31:0]           insn;
    logic [`MUL_ACC_W-1:0] acc;
  } mul_req_t;

  // Result word plus illegal flag
  typedef struct packed {
    logic [`MUL_XLEN-1:0] result;
    logic                 illegal;
  } mul_rsp_t;

endpackage

// ==== src/axil_pkg.sv ====
/* AXI4-Lite channel payloads for the register port.
   Data is MUL_XLEN wide with one strobe per byte; valid and ready travel beside the structs. */
`include "mul_settings.svh"

package axil_pkg;

  // Standard AXI response codes
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } axil_resp_e;

  // AW and AR payload
  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [2:0]              prot;
  } axil_addr_t;

  // W payload
  typedef struct packed {
    logic [`MUL_XLEN-1:0]   data;
    logic [`MUL_XLEN/8-1:0] strb;
  } axil_wdata_t;

  // B payload
  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

  // R payload
  typedef struct packed {
    logic [`MUL_XLEN-1:0] data;
    axil_resp_e           resp;
  } axil_r_t;

endpackage

// ==== src/axil_skid.sv ====
/* Registered two-entry skid buffer for one valid/ready channel.
   Output lags input by one cycle; in_ready comes straight from a flop. */
`timescale 1ns/1ps

module axil_skid #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     skid_valid;
  payload_t skid_data;

  // Second entry full means no room for more
  assign in_ready = ~skid_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_ready || !out_valid) begin
      // Output slot drains or is empty, refill from skid first
      if (skid_valid) begin
        out_valid  <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        out_valid <= in_valid;
      end
    end else if (in_valid && in_ready) begin
      // Stalled output, park the beat
      skid_valid <= 1'b1;
    end
  end

  // Payloads carry no reset
  always_ff @(posedge clk) begin
    if (out_ready || !out_valid) begin
      out_data <= skid_valid ? skid_data : in_data;
    end
    if (!(out_ready || !out_valid) && in_valid && in_ready) begin
      skid_data <= in_data;
    end
  end

endmodule

// ==== src/mul_decoder.sv ====
/* Decodes an RV32 instruction word into one of MUL, MULH, MULHSU or MULHU.
   Divide encodings and any other word come out as illegal with all flags cleared. */
`timescale 1ns/1ps

module mul_decoder
  import mul_pkg::*;
(
  input  logic [31:0]  insn,
  output mul_decoded_t dec
);

  // OP major opcode and the M extension funct7
  localparam logic [6:0] opcode_op   = 7'b0110011;
  localparam logic [6:0] funct7_mext = 7'b0000001;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  always_comb begin
    dec       = '0;
    dec.op    = mul_op_e'(funct3[1:0]);
    // funct3[2] set selects the divide group
    dec.legal = (opcode == opcode_op) && (funct7 == funct7_mext) && !funct3[2];
    case (dec.op)
      op_mul: begin
        // Low word is the same for any signedness
        dec.rs1_signed = 1'b1;
        dec.rs2_signed = 1'b1;
        dec.high       = 1'b0;
      end
      op_mulh: begin
        dec.rs1_signed = 1'b1;
        dec.rs2_signed = 1'b1;
        dec.high       = 1'b1;
      end
      op_mulhsu: begin
        dec.rs1_signed = 1'b1;
        dec.rs2_signed = 1'b0;
        dec.high       = 1'b1;
      end
      default: begin
        // MULHU
        dec.rs1_signed = 1'b0;
        dec.rs2_signed = 1'b0;
        dec.high       = 1'b1;
      end
    endcase
    // Illegal words carry no operation
    if (!dec.legal) begin
      dec = '0;
    end
  end

endmodule

// ==== src/approx_multiplier.sv ====
/* Sequential shift-add multiplier over operand magnitudes, one bit of b per cycle.
   Accuracy k skips the k low bits of |b|; done follows start by 33 - k cycles. */
`timescale 1ns/1ps
`include "mul_settings.svh"

module approx_multiplier (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  logic [`MUL_XLEN-1:0]    a,
  input  logic [`MUL_XLEN-1:0]    b,
  input  logic                    a_signed,
  input  logic                    b_signed,
  input  logic [`MUL_ACC_W-1:0]   acc,
  output logic                    busy,
  output logic                    done,
  output logic [2*`MUL_XLEN-1:0]  product
);

  localparam int xlen  = `MUL_XLEN;
  localparam int idx_w = $clog2(xlen);

  logic              a_neg;
  logic              b_neg;
  logic [xlen-1:0]   a_mag;
  logic [xlen-1:0]   b_mag;
  logic [xlen-1:0]   b_mask;
  logic              load;
  logic              last;
  logic [2*xlen-1:0] mcand_q;
  logic [xlen-1:0]   mplier_q;
  logic [idx_w-1:0]  idx_q;
  logic              neg_q;
  logic [2*xlen-1:0] sum_q;
  logic [2*xlen-1:0] sum_next;

  // Magnitudes, the most negative value maps to 2^31 unsigned
  assign a_neg = a_signed & a[xlen-1];
  assign b_neg = b_signed & b[xlen-1];
  assign a_mag = a_neg ? (~a + 1'b1) : a;
  assign b_mag = b_neg ? (~b + 1'b1) : b;

  // Low accuracy bits of |b| are dropped
  assign b_mask = {xlen{1'b1}} << acc;

  // One job at a time, start while busy is ignored
  assign load = start & ~busy;
  assign last = (idx_q == idx_w'(xlen - 1));

  // Partial product for the current bit of b
  assign sum_next = mplier_q[idx_q] ? (sum_q + mcand_q) : sum_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (load) begin
        busy <= 1'b1;
      end else if (busy && last) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  // Datapath, loaded on start and stepped while busy
  always_ff @(posedge clk) begin
    if (load) begin
      // Multiplicand pre-shifted to the first bit that counts
      mcand_q  <= {{xlen{1'b0}}, a_mag} << acc;
      mplier_q <= b_mag & b_mask;
      idx_q    <= idx_w'(acc);
      neg_q    <= a_neg ^ b_neg;
      sum_q    <= '0;
    end else if (busy) begin
      sum_q   <= sum_next;
      mcand_q <= mcand_q << 1;
      idx_q   <= idx_q + 1'b1;
      // Sign fixed up together with the last add
      if (last) begin
        product <= neg_q ? (~sum_next + 1'b1) : sum_next;
      end
    end
  end

endmodule

// ==== src/mul_unit.sv ====
/* RV32M multiply unit: decodes the held request, runs the multiplier and picks the word.
   A start while busy is dropped; illegal words finish next cycle with result 0. */
`timescale 1ns/1ps
`include "mul_settings.svh"

module mul_unit
  import mul_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     start,
  input  mul_req_t req,
  output logic     busy,
  output logic     done,
  output mul_rsp_t rsp
);

  localparam int xlen      = `MUL_XLEN;
  localparam bit approx_en = (`MUL_APPROX_ENABLE != 0);

  mul_req_t          req_q;
  mul_decoded_t      dec;
  logic              start_q;
  logic              mult_start;
  logic              mult_busy;
  logic              mult_done;
  logic [2*xlen-1:0] product;

  // Marks the cycle after an accepted start
  always_ff @(posedge clk) begin
    if (reset) begin
      start_q <= 1'b0;
    end else begin
      start_q <= start & ~busy;
    end
  end

  // Request held for the whole run
  always_ff @(posedge clk) begin
    if (start && !busy) begin
      req_q     <= req;
      // Exact mode ignores the accuracy field
      req_q.acc <= approx_en ? req.acc : '0;
    end
  end

  mul_decoder u_decoder (
    .insn (req_q.insn),
    .dec  (dec)
  );

  assign mult_start = start_q & dec.legal;

  approx_multiplier u_multiplier (
    .clk      (clk),
    .reset    (reset),
    .start    (mult_start),
    .a        (req_q.rs1),
    .b        (req_q.rs2),
    .a_signed (dec.rs1_signed),
    .b_signed (dec.rs2_signed),
    .acc      (req_q.acc),
    .busy     (mult_busy),
    .done     (mult_done),
    .product  (product)
  );

  // Busy covers the hand-off cycle and the multiplier run
  assign busy = mult_start | mult_busy;
  // Illegal word ends in the cycle after start
  assign done = mult_done | (start_q & ~dec.legal);

  always_comb begin
    rsp.illegal = ~dec.legal;
    if (!dec.legal) begin
      rsp.result = '0;
    end else if (dec.high) begin
      rsp.result = product[2*xlen-1:xlen];
    end else begin
      rsp.result = product[xlen-1:0];
    end
  end

endmodule

// ==== src/mul_axil_regs.sv ====
/* AXI4-Lite register block: operand, instruction, accuracy, control, status, result.
   Single outstanding write and read; unmapped reads give 0 and every response is OKAY. */
`timescale 1ns/1ps
`include "mul_settings.svh"

module mul_axil_regs
  import mul_pkg::*;
  import axil_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        aw_valid,
  output logic        aw_ready,
  input  axil_addr_t  aw,
  input  logic        w_valid,
  output logic        w_ready,
  input  axil_wdata_t w,
  output logic        b_valid,
  input  logic        b_ready,
  output axil_b_t     b,
  input  logic        ar_valid,
  output logic        ar_ready,
  input  axil_addr_t  ar,
  output logic        r_valid,
  input  logic        r_ready,
  output axil_r_t     r,
  output logic        start,
  output mul_req_t    req,
  input  logic        busy,
  input  logic        done,
  input  mul_rsp_t    rsp
);

  localparam int xlen  = `MUL_XLEN;
  localparam int acc_w = `MUL_ACC_W;

  logic [xlen-1:0]  rs1_q;
  logic [xlen-1:0]  rs2_q;
  logic [31:0]      insn_q;
  logic [acc_w-1:0] acc_q;
  logic [xlen-1:0]  result_q;
  logic             illegal_q;
  logic             done_q;
  logic             wr_en;
  logic             rd_en;
  logic [xlen-1:0]  rd_data;

  // Byte lanes with strobe set take the new data
  function automatic logic [xlen-1:0] merge_bytes(
    input logic [xlen-1:0]   old_val,
    input logic [xlen-1:0]   new_val,
    input logic [xlen/8-1:0] strb
  );
    logic [xlen-1:0] res;
    res = old_val;
    for (int i = 0; i < xlen / 8; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // AW and W taken together, blocked while B is pending
  assign wr_en    = aw_valid & w_valid & ~b_valid;
  assign aw_ready = w_valid & ~b_valid;
  assign w_ready  = aw_valid & ~b_valid;
  assign b.resp   = resp_okay;

  always_ff @(posedge clk) begin
    if (reset) begin
      rs1_q   <= '0;
      rs2_q   <= '0;
      insn_q  <= '0;
      acc_q   <= '0;
      start   <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      // Write of 1 to CTRL bit 0 gives a one-cycle pulse
      start <= wr_en && (aw.addr == `REG_CTRL) && w.strb[0] && w.data[0];
      if (wr_en) begin
        b_valid <= 1'b1;
      end else if (b_ready) begin
        b_valid <= 1'b0;
      end
      if (wr_en) begin
        case (aw.addr)
          `REG_RS1:  rs1_q  <= merge_bytes(rs1_q, w.data, w.strb);
          `REG_RS2:  rs2_q  <= merge_bytes(rs2_q, w.data, w.strb);
          `REG_INSN: insn_q <= merge_bytes(insn_q, w.data, w.strb);
          `REG_ACC: begin
            // Accuracy lives in byte 0
            if (w.strb[0]) begin
              acc_q <= w.data[acc_w-1:0];
            end
          end
          default: ;
        endcase
      end
    end
  end

  assign req = '{rs1: rs1_q, rs2: rs2_q, insn: insn_q, acc: acc_q};

  // Result capture and sticky done
  always_ff @(posedge clk) begin
    if (reset) begin
      done_q    <= 1'b0;
      illegal_q <= 1'b0;
      result_q  <= '0;
    end else begin
      if (done) begin
        result_q  <= rsp.result;
        illegal_q <= rsp.illegal;
      end
      // A new start wins over a finishing run
      if (start) begin
        done_q <= 1'b0;
      end else if (done) begin
        done_q <= 1'b1;
      end
    end
  end

  // Read side, one read in flight
  assign ar_ready = ~r_valid;
  assign rd_en    = ar_valid & ar_ready;

  always_comb begin
    case (ar.addr)
      `REG_RS1:    rd_data = rs1_q;
      `REG_RS2:    rd_data = rs2_q;
      `REG_INSN:   rd_data = insn_q;
      `REG_ACC:    rd_data = {{(xlen - acc_w){1'b0}}, acc_q};
      `REG_STATUS: rd_data = {{(xlen - 3){1'b0}}, illegal_q, done_q, busy};
      `REG_RESULT: rd_data = result_q;
      // CTRL is write-only
      default:     rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      r_valid <= 1'b0;
    end else if (rd_en) begin
      r_valid <= 1'b1;
    end else if (r_ready) begin
      r_valid <= 1'b0;
    end
  end

  // Read payload held until rready
  always_ff @(posedge clk) begin
    if (rd_en) begin
      r.data <= rd_data;
      r.resp <= resp_okay;
    end
  end

endmodule

// ==== src/mul_axil_top.sv ====
/* Top level of the AXI4-Lite multiply unit.
   AW, W and AR pass through skid buffers; B and R come straight from the register block. */
`timescale 1ns/1ps

module mul_axil_top
  import mul_pkg::*;
  import axil_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        aw_valid,
  output logic        aw_ready,
  input  axil_addr_t  aw,
  input  logic        w_valid,
  output logic        w_ready,
  input  axil_wdata_t w,
  output logic        b_valid,
  input  logic        b_ready,
  output axil_b_t     b,
  input  logic        ar_valid,
  output logic        ar_ready,
  input  axil_addr_t  ar,
  output logic        r_valid,
  input  logic        r_ready,
  output axil_r_t     r
);

  // Channels after the skid buffers
  logic        aw_s_valid;
  logic        aw_s_ready;
  axil_addr_t  aw_s;
  logic        w_s_valid;
  logic        w_s_ready;
  axil_wdata_t w_s;
  logic        ar_s_valid;
  logic        ar_s_ready;
  axil_addr_t  ar_s;

  // Register block to multiply unit
  logic        start;
  logic        busy;
  logic        done;
  mul_req_t    req;
  mul_rsp_t    rsp;

  axil_skid #(.payload_t(axil_addr_t)) u_aw_skid (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (aw_valid),
    .in_ready  (aw_ready),
    .in_data   (aw),
    .out_valid (aw_s_valid),
    .out_ready (aw_s_ready),
    .out_data  (aw_s)
  );

  axil_skid #(.payload_t(axil_wdata_t)) u_w_skid (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (w_valid),
    .in_ready  (w_ready),
    .in_data   (w),
    .out_valid (w_s_valid),
    .out_ready (w_s_ready),
    .out_data  (w_s)
  );

  axil_skid #(.payload_t(axil_addr_t)) u_ar_skid (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (ar_valid),
    .in_ready  (ar_ready),
    .in_data   (ar),
    .out_valid (ar_s_valid),
    .out_ready (ar_s_ready),
    .out_data  (ar_s)
  );

  mul_axil_regs u_regs (
    .clk      (clk),
    .reset    (reset),
    .aw_valid (aw_s_valid),
    .aw_ready (aw_s_ready),
    .aw       (aw_s),
    .w_valid  (w_s_valid),
    .w_ready  (w_s_ready),
    .w        (w_s),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b        (b),
    .ar_valid (ar_s_valid),
    .ar_ready (ar_s_ready),
    .ar       (ar_s),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r        (r),
    .start    (start),
    .req      (req),
    .busy     (busy),
    .done     (done),
    .rsp      (rsp)
  );

  mul_unit u_mul_unit (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .req   (req),
    .busy  (busy),
    .done  (done),
    .rsp   (rsp)
  );

endmodule

// ==== bench/mul_tb_asserts.sv ====
/* Protocol and status assertions for mul_axil_top, attached with bind.
   Busy and done are the internal handshake between the register block and the multiply unit. */
`timescale 1ns/1ps

module mul_tb_asserts
  import axil_pkg::*;
(
  input logic    clk,
  input logic    reset,
  input logic    b_valid,
  input logic    b_ready,
  input axil_b_t b,
  input logic    r_valid,
  input logic    r_ready,
  input axil_r_t r,
  input logic    busy,
  input logic    done
);

  // B held with its payload until taken
  a_b_stable: assert property (@(posedge clk) disable iff (reset)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else $error("B channel changed before bready");

  // R held with its payload until taken
  a_r_stable: assert property (@(posedge clk) disable iff (reset)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else $error("R channel changed before rready");

  // A run is either going or just finished
  a_busy_done: assert property (@(posedge clk) disable iff (reset)
    !(busy && done))
    else $error("busy and done high together");

  // Unit idle right after reset
  a_reset_idle: assert property (@(posedge clk)
    reset |=> !busy && !done)
    else $error("busy or done high after reset");

endmodule

bind mul_axil_top mul_tb_asserts u_asserts (
  .clk     (clk),
  .reset   (reset),
  .b_valid (b_valid),
  .b_ready (b_ready),
  .b       (b),
  .r_valid (r_valid),
  .r_ready (r_ready),
  .r       (r),
  .busy    (busy),
  .done    (done)
);

// ==== bench/mul_tb.sv ====
/* Directed testbench for the AXI4-Lite multiply unit, inputs driven on the falling edge.
   Every handshake and STATUS poll is bounded; a timeout ends the run at once. */
`timescale 1ns/1ps
`include "mul_settings.svh"

module mul_tb
  import axil_pkg::*;
();

  localparam int hs_limit   = 50;
  localparam int poll_limit = 100;
  localparam logic [6:0] opcode_op = 7'b0110011;
  localparam logic [6:0] funct7_m  = 7'b0000001;

  logic        clk;
  logic        reset;
  logic        aw_valid;
  logic        aw_ready;
  axil_addr_t  aw;
  logic        w_valid;
  logic        w_ready;
  axil_wdata_t w;
  logic        b_valid;
  logic        b_ready;
  axil_b_t     b;
  logic        ar_valid;
  logic        ar_ready;
  axil_addr_t  ar;
  logic        r_valid;
  logic        r_ready;
  axil_r_t     r;

  int errors;
  int tests;
  int failed_tests;

  mul_axil_top u_dut (
    .clk      (clk),
    .reset    (reset),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw       (aw),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w        (w),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b        (b),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar       (ar),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r        (r)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Stuck handshake or poll ends the run
  task automatic fail_timeout(input string what);
    $display("Timeout at %0t ns: the DUT never gave %s", $time, what);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      failed_tests++;
      $display("%s: %0d errors", name, errors - errors_before);
    end
  endtask

  // Call just after a falling edge
  // b_hold keeps bready low that many cycles
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int b_hold);
    logic aw_hs;
    logic w_hs;
    int   t;
    aw       = '{addr: addr, prot: 3'b000};
    w        = '{data: data, strb: strb};
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    t        = 0;
    // Ready values come from flops and hold until the rising edge
    while (aw_valid || w_valid) begin
      aw_hs = aw_valid && aw_ready;
      w_hs  = w_valid && w_ready;
      @(negedge clk);
      if (aw_hs) aw_valid = 1'b0;
      if (w_hs) w_valid = 1'b0;
      t++;
      if (t > hs_limit) fail_timeout("awready or wready");
    end
    repeat (b_hold) @(negedge clk);
    b_ready = 1'b1;
    t       = 0;
    while (!b_valid) begin
      @(negedge clk);
      t++;
      if (t > hs_limit) fail_timeout("bvalid");
    end
    check(32'(b.resp), 32'(resp_okay), "write response code");
    // Response taken on the next rising edge
    @(negedge clk);
    b_ready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, input int r_hold, output logic [31:0] data);
    int t;
    ar       = '{addr: addr, prot: 3'b000};
    ar_valid = 1'b1;
    t        = 0;
    while (!ar_ready) begin
      @(negedge clk);
      t++;
      if (t > hs_limit) fail_timeout("arready");
    end
    @(negedge clk);
    ar_valid = 1'b0;
    repeat (r_hold) @(negedge clk);
    r_ready = 1'b1;
    t       = 0;
    while (!r_valid) begin
      @(negedge clk);
      t++;
      if (t > hs_limit) fail_timeout("rvalid");
    end
    data = r.data;
    check(32'(r.resp), 32'(resp_okay), "read response code");
    @(negedge clk);
    r_ready = 1'b0;
  endtask

  // R-type word with fixed register fields
  function automatic logic [31:0] mul_insn(input logic [6:0] funct7, input logic [2:0] funct3,
                                           input logic [6:0] opcode);
    return {funct7, 5'd12, 5'd11, funct3, 5'd10, opcode};
  endfunction

  // Sign-corrected product of |rs1| and |rs2| with the k low bits of |rs2| cleared
  function automatic logic [31:0] model_mul(input logic [31:0] a, input logic [31:0] bv,
                                            input logic [2:0] f3, input int k);
    logic        a_neg;
    logic        b_neg;
    logic [31:0] a_mag;
    logic [31:0] b_mag;
    logic [63:0] p;
    // rs1 is unsigned only for MULHU and rs2 is unsigned for MULHSU and MULHU
    a_neg = (f3 != 3'd3) && a[31];
    b_neg = (f3 == 3'd0 || f3 == 3'd1) && bv[31];
    a_mag = a_neg ? -a : a;
    b_mag = b_neg ? -bv : bv;
    b_mag = b_mag & (32'hffff_ffff << k);
    p     = {32'd0, a_mag} * {32'd0, b_mag};
    if (a_neg ^ b_neg) p = -p;
    // MUL keeps the low word
    return (f3 == 3'd0) ? p[31:0] : p[63:32];
  endfunction

  // Load operands, start the unit and wait for the done bit
  task automatic run_op(input logic [31:0] a, input logic [31:0] bv, input logic [31:0] insn,
                        input logic [3:0] k, output logic [31:0] result,
                        output logic [31:0] status);
    int polls;
    axil_write(`REG_RS1, a, 4'hf, 0);
    axil_write(`REG_RS2, bv, 4'hf, 0);
    axil_write(`REG_INSN, insn, 4'hf, 0);
    axil_write(`REG_ACC, {28'd0, k}, 4'hf, 0);
    axil_write(`REG_CTRL, 32'd1, 4'hf, 0);
    polls  = 0;
    status = '0;
    while (!status[1]) begin
      axil_read(`REG_STATUS, 0, status);
      polls++;
      if (polls > poll_limit) fail_timeout("the done bit in STATUS");
    end
    axil_read(`REG_RESULT, 0, result);
  endtask

  task automatic check_op(input logic [31:0] a, input logic [31:0] bv, input logic [2:0] f3,
                          input logic [3:0] k);
    logic [31:0] result;
    logic [31:0] status;
    logic [31:0] exp;
    int          k_eff;
    // Exact mode ignores the accuracy field
    k_eff = (`MUL_APPROX_ENABLE != 0) ? int'(k) : 0;
    exp   = model_mul(a, bv, f3, k_eff);
    run_op(a, bv, mul_insn(funct7_m, f3, opcode_op), k, result, status);
    check(result, exp, $sformatf("funct3 %0d a %h b %h k %0d result", f3, a, bv, k));
    check(32'(status[2]), 32'd0, "illegal flag on a multiply");
  endtask

  task automatic register_access();
    logic [31:0] v;
    int          e0;
    e0 = errors;
    axil_write(`REG_RS1, 32'h1234_5678, 4'hf, 0);
    axil_read(`REG_RS1, 0, v);
    check(v, 32'h1234_5678, "RS1 full write");
    axil_write(`REG_RS1, 32'haabb_ccdd, 4'b0101, 0);
    axil_read(`REG_RS1, 0, v);
    check(v, 32'h12bb_56dd, "RS1 bytes 0 and 2");
    axil_write(`REG_RS2, 32'hcafe_f00d, 4'hf, 0);
    axil_write(`REG_RS2, 32'h5a5a_5a5a, 4'b1000, 0);
    axil_read(`REG_RS2, 0, v);
    check(v, 32'h5afe_f00d, "RS2 byte 3");
    axil_write(`REG_INSN, 32'h02c5_8533, 4'hf, 0);
    axil_write(`REG_INSN, 32'h0000_ff00, 4'b0010, 0);
    axil_read(`REG_INSN, 0, v);
    check(v, 32'h02c5_ff33, "INSN byte 1");
    // Only four accuracy bits exist and all sit in byte 0
    axil_write(`REG_ACC, 32'hffff_fff7, 4'hf, 0);
    axil_read(`REG_ACC, 0, v);
    check(v, 32'h0000_0007, "ACC full write");
    axil_write(`REG_ACC, 32'h0000_0a00, 4'b0010, 0);
    axil_read(`REG_ACC, 0, v);
    check(v, 32'h0000_0007, "ACC with byte 0 not strobed");
    axil_write(`REG_ACC, 32'h0000_000b, 4'b0001, 0);
    axil_read(`REG_ACC, 0, v);
    check(v, 32'h0000_000b, "ACC byte 0");
    axil_read(8'h1c, 0, v);
    check(v, 32'd0, "unmapped offset 0x1c");
    axil_read(8'hfc, 0, v);
    check(v, 32'd0, "unmapped offset 0xfc");
    report_test("register_access", e0);
  endtask

  task automatic exact_products();
    logic [31:0] corners [5];
    int          e0;
    e0      = errors;
    corners = '{32'd0, 32'd1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    // Every corner pair for all four operations
    for (int f3 = 0; f3 < 4; f3++) begin
      foreach (corners[i]) begin
        foreach (corners[j]) begin
          check_op(corners[i], corners[j], 3'(f3), 4'd0);
        end
      end
    end
    repeat (40) begin
      logic [31:0] a;
      logic [31:0] bv;
      a  = $urandom();
      bv = $urandom();
      for (int f3 = 0; f3 < 4; f3++) begin
        check_op(a, bv, 3'(f3), 4'd0);
      end
    end
    report_test("exact_products", e0);
  endtask

  task automatic approx_products();
    int e0;
    e0 = errors;
    for (int f3 = 0; f3 < 4; f3++) begin
      for (int k = 1; k < 16; k++) begin
        check_op($urandom(), $urandom(), 3'(f3), 4'(k));
      end
    end
    report_test("approx_products", e0);
  endtask

  task automatic illegal_words();
    logic [31:0] words [6];
    logic [31:0] result;
    logic [31:0] status;
    int          e0;
    e0 = errors;
    // Words are ADD, a multiply with the LUI opcode and the divide group
    words[0] = mul_insn(7'b0000000, 3'd0, opcode_op);
    words[1] = mul_insn(funct7_m, 3'd1, 7'b0110111);
    for (int f3 = 4; f3 < 8; f3++) begin
      words[f3 - 2] = mul_insn(funct7_m, 3'(f3), opcode_op);
    end
    foreach (words[i]) begin
      run_op(32'h1234_5678, 32'h9abc_def0, words[i], 4'd0, result, status);
      check(32'(status[2]), 32'd1, $sformatf("illegal flag for insn %h", words[i]));
      // An illegal word never starts the multiplier
      check(32'(status[0]), 32'd0, $sformatf("busy bit for insn %h", words[i]));
      check(result, 32'd0, $sformatf("result for insn %h", words[i]));
    end
    report_test("illegal_words", e0);
  endtask

  task automatic start_while_busy();
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] bv;
    logic [31:0] status;
    logic [31:0] result;
    int          polls;
    int          e0;
    e0 = errors;
    a0 = 32'h8765_4321;
    a1 = 32'h0000_0777;
    bv = 32'hf00f_1234;
    // Full-length run gives room for a second start
    axil_write(`REG_RS1, a0, 4'hf, 0);
    axil_write(`REG_RS2, bv, 4'hf, 0);
    axil_write(`REG_INSN, mul_insn(funct7_m, 3'd1, opcode_op), 4'hf, 0);
    axil_write(`REG_ACC, 32'd0, 4'hf, 0);
    axil_write(`REG_CTRL, 32'd1, 4'hf, 0);
    axil_write(`REG_RS1, a1, 4'hf, 0);
    axil_write(`REG_CTRL, 32'd1, 4'hf, 0);
    axil_read(`REG_STATUS, 0, status);
    check(status[1:0], 32'd1, "STATUS while busy");
    for (int run = 0; run < 2; run++) begin
      polls  = 0;
      status = '0;
      while (!status[1]) begin
        axil_read(`REG_STATUS, 0, status);
        polls++;
        if (polls > poll_limit) fail_timeout("the done bit in STATUS");
      end
      axil_read(`REG_RESULT, 0, result);
      check(result, model_mul(run == 0 ? a0 : a1, bv, 3'd1, 0),
            $sformatf("result of run %0d", run));
      if (run == 0) begin
        // Accepted start clears the sticky done bit
        axil_write(`REG_CTRL, 32'd1, 4'hf, 0);
        axil_read(`REG_STATUS, 0, status);
        check(status[1:0], 32'd1, "STATUS after a new start");
        status = '0;
      end
    end
    report_test("start_while_busy", e0);
  endtask

  task automatic back_pressure();
    logic [31:0] a;
    logic [31:0] bv;
    logic [31:0] v;
    int          e0;
    e0 = errors;
    a  = $urandom();
    bv = $urandom();
    // B and R held off for several cycles
    axil_write(`REG_RS1, a, 4'hf, 6);
    axil_write(`REG_RS2, bv, 4'hf, 3);
    axil_read(`REG_RS1, 7, v);
    check(v, a, "RS1 under back-pressure");
    axil_read(`REG_RS2, 5, v);
    check(v, bv, "RS2 under back-pressure");
    check_op(a, bv, 3'd2, 4'd5);
    axil_read(`REG_RESULT, 8, v);
    check(v, model_mul(a, bv, 3'd2, (`MUL_APPROX_ENABLE != 0) ? 5 : 0),
          "RESULT under back-pressure");
    report_test("back_pressure", e0);
  endtask

  initial begin
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    reset        = 1'b1;
    aw_valid     = 1'b0;
    aw           = '0;
    w_valid      = 1'b0;
    w            = '0;
    b_ready      = 1'b0;
    ar_valid     = 1'b0;
    ar           = '0;
    r_ready      = 1'b0;
    void'($urandom(32'hcb49));
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    register_access();
    exact_products();
    approx_products();
    illegal_words();
    start_while_busy();
    back_pressure();
    $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+src
src/mul_pkg.sv
src/axil_pkg.sv
src/axil_skid.sv
src/mul_decoder.sv
src/approx_multiplier.sv
src/mul_unit.sv
src/mul_axil_regs.sv
src/mul_axil_top.sv
bench/mul_tb_asserts.sv
bench/mul_tb.sv
